// ==== files.f ====
+incdir+design
design/mvm_data_pkg.sv
design/mvm_ctrl_pkg.sv
design/chunk_if.sv
design/ram_1w1r.sv
design/n2r_buffer.sv
design/slice_mac.sv
design/mvm_top.sv
verif/mvm_props.sv
verif/mvm_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile with Verilator, run, then search the log for the fail message
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG" build.log

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module mvm_tb -o Vmvm_tb > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

# A nonzero exit, for example from an assertion, counts as a failure
./obj_dir/Vmvm_tb > "$LOG" 2>&1 || echo "Verification failed" >> "$LOG"
cat "$LOG"

grep -q "Verification failed" "$LOG" && { echo "Simulation FAILED"; exit 1; } \
    || { echo "Simulation PASSED"; exit 0; }

// ==== verif/mvm_tb.sv ====
////////////////////////////////////////////////////////////
// Testbench for the matrix-vector multiply front end
// Three runs with random data, back-pressure and row gaps
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "mvm_defs.svh"

module mvm_tb;
    import mvm_data_pkg::*;
    import mvm_ctrl_pkg::*;

    localparam int NUM_RUNS   = 3;
    // Reset, start, gapped fill, stalled slices and drain
    localparam int RUN_CYCLES = 7 + `MVM_ROWS * 5
                              + NUM_SLICES * (SLICE_ROWS + 1 + 3 * NUM_COL_BLK) + 20;
    localparam int TIMEOUT_NS = 4 * NUM_RUNS * RUN_CYCLES * 20;

    logic          clk;
    logic          rst_n;
    logic          start;
    logic          row_valid;
    logic          row_ready;
    row_t          row_data;
    weight_vec_t   weights;
    logic          res_valid;
    logic          res_ready;
    slice_result_t res_data;
    logic          res_last;
    logic          done;

    row_t          matrix [`MVM_ROWS];
    slice_result_t exp_q [$];
    bit            bp_enable = 1'b0;
    int            beats_seen = 0;
    int            run_base = 0;
    int            value_errors = 0;
    int            other_errors = 0;

    mvm_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .row_valid (row_valid),
        .row_ready (row_ready),
        .row_data  (row_data),
        .weights   (weights),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_data  (res_data),
        .res_last  (res_last),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            value_errors++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    // Expected Q8.8 result of one row
    function automatic elem_t ref_row_result(row_t r, weight_vec_t w);
        longint sum;
        sum = 0;
        for (int c = 0; c < `MVM_COLS; c++) begin
            sum += longint'(r[c]) * longint'(w[c]);
        end
        return elem_t'(sum >>> `MVM_FRAC);
    endfunction

    // Magnitude up to 2.0
    function automatic elem_t rand_elem();
        int v;
        v = int'($urandom % 1024) - 512;
        return elem_t'(v);
    endfunction

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
    endtask

    task automatic check_idle_outputs();
        repeat (2) @(negedge clk);
        check_value("row_ready before start", 64'(row_ready), 64'd0);
        check_value("res_valid before start", 64'(res_valid), 64'd0);
        check_value("done before start", 64'(done), 64'd0);
        @(posedge clk);
        #2;
    endtask

    task automatic send_row(input row_t data, input bit with_gap);
        int  idle;
        bit  accepted;
        if (with_gap) begin
            idle = int'($urandom % 4);
            row_valid = 1'b0;
            repeat (idle) begin
                @(posedge clk);
                #2;
            end
        end
        row_valid = 1'b1;
        row_data  = data;
        accepted  = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = row_ready;
            @(posedge clk);
            #2;
        end
        row_valid = 1'b0;
    endtask

    task automatic run_matrix(input bit backpressure, input bit row_gaps);
        slice_result_t exp_word;
        weight_vec_t   wvec;
        bp_enable = backpressure;
        run_base  = beats_seen;
        for (int r = 0; r < `MVM_ROWS; r++) begin
            for (int c = 0; c < `MVM_COLS; c++) begin
                matrix[r][c] = rand_elem();
            end
        end
        for (int c = 0; c < `MVM_COLS; c++) begin
            wvec[c] = rand_elem();
        end
        for (int s = 0; s < NUM_SLICES; s++) begin
            for (int i = 0; i < SLICE_ROWS; i++) begin
                exp_word[i] = ref_row_result(matrix[s*SLICE_ROWS + i], wvec);
            end
            exp_q.push_back(exp_word);
        end
        weights = wvec;
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        for (int r = 0; r < `MVM_ROWS; r++) begin
            send_row(matrix[r], row_gaps);
        end
        wait (beats_seen - run_base == NUM_SLICES);
        repeat (4) begin
            @(negedge clk);
            check_value("done held high", 64'(done), 64'd1);
        end
        repeat (8) @(posedge clk);
        #2;
        check_value("result beat count", 64'(beats_seen - run_base), 64'(NUM_SLICES));
    endtask

    // Random stall on the result stream when enabled
    initial begin
        res_ready = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            res_ready = bp_enable ? (($urandom % 3) != 0) : 1'b1;
        end
    end

    // Result checker, samples between edges
    always @(negedge clk) begin
        slice_result_t expected;
        int            idx;
        if (rst_n && res_valid && res_ready) begin
            idx = beats_seen - run_base;
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("A result beat arrived at time %0t when none was expected", $time);
            end else begin
                expected = exp_q.pop_front();
                check_value($sformatf("slice %0d data", idx), res_data, expected);
                check_value($sformatf("slice %0d last", idx), 64'(res_last),
                            64'(idx == NUM_SLICES - 1));
                if (idx == NUM_SLICES - 1) begin
                    check_value("done at final result", 64'(done), 64'd1);
                end
            end
            beats_seen++;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("The run timed out before all results arrived");
        $display("Verification failed");
        $finish;
    end

    initial begin
        void'($urandom(17765));
        rst_n     = 1'b0;
        start     = 1'b0;
        row_valid = 1'b0;
        row_data  = '0;
        weights   = '0;
        apply_reset();
        check_idle_outputs();
        run_matrix(1'b0, 1'b0);
        apply_reset();
        check_idle_outputs();
        run_matrix(1'b1, 1'b0);
        apply_reset();
        check_idle_outputs();
        run_matrix(1'b1, 1'b1);
        $display("Run complete with %0d value errors and %0d other errors",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/mvm_props.sv ====
////////////////////////////////////////////////////////////
// Handshake assertions for the reorder buffer and results
// Attached to the top level by the bind at the end
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "mvm_defs.svh"

module mvm_props (
    input wire                              clk,
    input wire                              rst_n,
    input wire                              start,
    input wire                              row_valid,
    input wire                              row_ready,
    input wire                              chunk_valid,
    input wire                              chunk_ready,
    input wire                              chunk_last,
    input wire mvm_data_pkg::lane_chunks_t  chunks,
    input wire                              res_valid
);
    // Set once the first slice's last chunk is taken
    logic slice_seen;

    // Fill window runs from start until every row is taken
    logic                       started;
    logic [$clog2(`MVM_ROWS):0] rows_taken;
    logic                       in_fill;

    assign in_fill = started && (rows_taken < `MVM_ROWS);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slice_seen <= 1'b0;
        end else if (chunk_valid && chunk_ready && chunk_last) begin
            slice_seen <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            started    <= 1'b0;
            rows_taken <= '0;
        end else begin
            if (start) begin
                started <= 1'b1;
            end
            if (row_valid && row_ready) begin
                rows_taken <= rows_taken + 1'b1;
            end
        end
    end

    chunk_hold: assert property (@(posedge clk) disable iff (!rst_n)
        chunk_valid && !chunk_ready |=>
            chunk_valid && $stable(chunks) && $stable(chunk_last))
        else $error("chunk beat dropped or changed before it was accepted");

    row_ready_in_fill: assert property (@(posedge clk) disable iff (!rst_n)
        !in_fill |-> !row_ready)
        else $error("row_ready high outside the fill phase");

    no_chunk_in_fill: assert property (@(posedge clk) disable iff (!rst_n)
        in_fill |-> !chunk_valid)
        else $error("chunk valid high during the fill phase");

    no_early_result: assert property (@(posedge clk) disable iff (!rst_n)
        !slice_seen |-> !res_valid)
        else $error("result valid before any slice finished");

endmodule

bind mvm_top mvm_props u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .row_valid   (row_valid),
    .row_ready   (row_ready),
    .chunk_valid (chunk_bus.valid),
    .chunk_ready (chunk_bus.ready),
    .chunk_last  (chunk_bus.last),
    .chunks      (chunk_bus.chunks),
    .res_valid   (res_valid)
);

`default_nettype wire

// ==== design/mvm_top.sv ====
////////////////////////////////////////////////////////////
// Matrix-vector multiply front end, top level
// Row stream in, weights held steady, slice results out
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module mvm_top (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire                                start,
    input  wire                                row_valid,
    output wire                                row_ready,
    input  wire mvm_data_pkg::row_t            row_data,
    input  wire mvm_data_pkg::weight_vec_t     weights,
    output wire                                res_valid,
    input  wire                                res_ready,
    output wire mvm_data_pkg::slice_result_t   res_data,
    output wire                                res_last,
    output wire                                done
);
    import mvm_data_pkg::*;
    import mvm_ctrl_pkg::*;

    logic     ram_we;
    row_idx_t ram_waddr;
    row_idx_t ram_raddr;
    row_t     ram_din;
    row_t     ram_dout;

    chunk_if chunk_bus ();

    ram_1w1r u_ram (
        .clk   (clk),
        .we    (ram_we),
        .waddr (ram_waddr),
        .din   (ram_din),
        .raddr (ram_raddr),
        .dout  (ram_dout)
    );

    n2r_buffer u_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .row_valid (row_valid),
        .row_ready (row_ready),
        .row_data  (row_data),
        .ram_we    (ram_we),
        .ram_waddr (ram_waddr),
        .ram_din   (ram_din),
        .ram_raddr (ram_raddr),
        .ram_dout  (ram_dout),
        .chunk     (chunk_bus.source),
        .done      (done)
    );

    slice_mac u_mac (
        .clk       (clk),
        .rst_n     (rst_n),
        .weights   (weights),
        .chunk     (chunk_bus.sink),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_data  (res_data),
        .res_last  (res_last)
    );

endmodule

`default_nettype wire

// ==== design/slice_mac.sv ====
////////////////////////////////////////////////////////////
// Lane array of block multiply-accumulate cores
// One result beat per slice, held until accepted downstream
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "mvm_defs.svh"

module slice_mac (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire mvm_data_pkg::weight_vec_t    weights,
    chunk_if.sink                             chunk,
    output logic                              res_valid,
    input  wire                               res_ready,
    output mvm_data_pkg::slice_result_t       res_data,
    output logic                              res_last
);
    import mvm_data_pkg::*;
    import mvm_ctrl_pkg::*;

    col_blk_t   col_blk;
    slice_idx_t slice_cnt;

    // Indexed by slice row, lane c owns rows c*BLOCK..c*BLOCK+BLOCK-1
    acc_t acc      [SLICE_ROWS];
    acc_t acc_next [SLICE_ROWS];

    logic beat_acc;
    logic load;

    // Stall the chunk stream while a result waits
    assign chunk.ready = !res_valid || res_ready;
    assign beat_acc    = chunk.valid && chunk.ready;
    assign load        = beat_acc && chunk.last;

    always_comb begin
        for (int c = 0; c < `MVM_CORES; c++) begin
            for (int r = 0; r < `MVM_BLOCK; r++) begin
                acc_next[c*`MVM_BLOCK + r] = acc[c*`MVM_BLOCK + r];
                for (int k = 0; k < `MVM_BLOCK; k++) begin
                    acc_next[c*`MVM_BLOCK + r] = acc_next[c*`MVM_BLOCK + r]
                        + acc_t'(chunk.chunks[c][r*`MVM_BLOCK + k])
                        * acc_t'(weights[col_blk*`MVM_BLOCK + k]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < SLICE_ROWS; i++) begin
                acc[i] <= '0;
            end
            col_blk   <= '0;
            slice_cnt <= '0;
        end else if (load) begin
            // Fresh sums for the next slice
            for (int i = 0; i < SLICE_ROWS; i++) begin
                acc[i] <= '0;
            end
            col_blk   <= '0;
            slice_cnt <= (slice_cnt == slice_idx_t'(NUM_SLICES - 1)) ? '0 : slice_cnt + 1'b1;
        end else if (beat_acc) begin
            for (int i = 0; i < SLICE_ROWS; i++) begin
                acc[i] <= acc_next[i];
            end
            col_blk <= col_blk + 1'b1;
        end
    end

    // Back to Q8.8 by plain truncation
    always_ff @(posedge clk) begin
        if (load) begin
            for (int i = 0; i < SLICE_ROWS; i++) begin
                res_data[i] <= elem_t'(acc_next[i] >>> `MVM_FRAC);
            end
            res_last <= (slice_cnt == slice_idx_t'(NUM_SLICES - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else if (load) begin
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/n2r_buffer.sv ====
////////////////////////////////////////////////////////////
// Normal-to-ready buffer: stores the matrix row by row, then
// replays it slice by slice as per-core 2x2 block chunks
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "mvm_defs.svh"

module n2r_buffer (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            start,
    input  wire                            row_valid,
    output logic                           row_ready,
    input  wire mvm_data_pkg::row_t        row_data,
    output logic                           ram_we,
    output mvm_ctrl_pkg::row_idx_t         ram_waddr,
    output mvm_data_pkg::row_t             ram_din,
    output mvm_ctrl_pkg::row_idx_t         ram_raddr,
    input  wire mvm_data_pkg::row_t        ram_dout,
    chunk_if.source                        chunk,
    output logic                           done
);
    import mvm_data_pkg::*;
    import mvm_ctrl_pkg::*;

    n2r_state_t state;
    n2r_state_t state_next;

    row_idx_t wr_cnt;
    row_idx_t slice_base;
    // Runs 0..SLICE_ROWS, one extra cycle for read latency
    row_idx_t rd_cnt;
    col_blk_t col_blk;

    row_t slice_reg [SLICE_ROWS];

    logic row_acc;
    logic beat_acc;
    logic last_row;
    logic last_slice;
    logic rd_last;

    assign row_acc    = row_valid && row_ready;
    assign beat_acc   = chunk.valid && chunk.ready;
    assign last_row   = (wr_cnt == row_idx_t'(`MVM_ROWS - 1));
    assign last_slice = (slice_base == row_idx_t'(`MVM_ROWS - SLICE_ROWS));
    assign rd_last    = (rd_cnt == row_idx_t'(SLICE_ROWS));

    assign row_ready   = (state == ST_FILL);
    assign chunk.valid = (state == ST_EMIT);
    assign chunk.last  = (col_blk == col_blk_t'(NUM_COL_BLK - 1));
    assign done        = (state == ST_DONE);
    assign ram_raddr   = slice_base + rd_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    state_next = ST_FILL;
                end
            end
            ST_FILL: begin
                if (row_acc && last_row) begin
                    state_next = ST_SLICE_RD;
                end
            end
            ST_SLICE_RD: begin
                if (rd_last) begin
                    state_next = ST_EMIT;
                end
            end
            ST_EMIT: begin
                if (beat_acc && chunk.last) begin
                    state_next = last_slice ? ST_DONE : ST_SLICE_RD;
                end
            end
            // Held until reset
            ST_DONE: state_next = ST_DONE;
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_cnt     <= '0;
            slice_base <= '0;
            rd_cnt     <= '0;
            col_blk    <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    wr_cnt     <= '0;
                    slice_base <= '0;
                    rd_cnt     <= '0;
                    col_blk    <= '0;
                end
                ST_FILL: begin
                    if (row_acc) begin
                        wr_cnt <= wr_cnt + 1'b1;
                    end
                end
                ST_SLICE_RD: begin
                    rd_cnt <= rd_last ? '0 : rd_cnt + 1'b1;
                end
                ST_EMIT: begin
                    if (beat_acc && chunk.last) begin
                        col_blk <= '0;
                        if (!last_slice) begin
                            slice_base <= slice_base + row_idx_t'(SLICE_ROWS);
                        end
                    end else if (beat_acc) begin
                        col_blk <= col_blk + 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // Accepted row goes to RAM on the following cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ram_we <= 1'b0;
        end else begin
            ram_we <= row_acc;
        end
    end

    always_ff @(posedge clk) begin
        if (row_acc) begin
            ram_waddr <= wr_cnt;
            ram_din   <= row_data;
        end
    end

    // Shift in read data, the slice's lowest row ends up in entry 0
    always_ff @(posedge clk) begin
        if (state == ST_SLICE_RD && rd_cnt != '0) begin
            for (int i = 0; i < SLICE_ROWS - 1; i++) begin
                slice_reg[i] <= slice_reg[i + 1];
            end
            slice_reg[SLICE_ROWS - 1] <= ram_dout;
        end
    end

    // Core c takes slice rows c*BLOCK.. at the current column block
    always_comb begin
        for (int c = 0; c < `MVM_CORES; c++) begin
            for (int r = 0; r < `MVM_BLOCK; r++) begin
                for (int k = 0; k < `MVM_BLOCK; k++) begin
                    chunk.chunks[c][r*`MVM_BLOCK + k] =
                        slice_reg[c*`MVM_BLOCK + r][col_blk*`MVM_BLOCK + k];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/ram_1w1r.sv ====
////////////////////////////////////////////////////////////
// Row storage, one write port and one registered read port
// Read data appears one cycle after the address
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "mvm_defs.svh"

module ram_1w1r (
    input  wire                            clk,
    input  wire                            we,
    input  wire mvm_ctrl_pkg::row_idx_t    waddr,
    input  wire mvm_data_pkg::row_t        din,
    input  wire mvm_ctrl_pkg::row_idx_t    raddr,
    output mvm_data_pkg::row_t             dout
);
    import mvm_data_pkg::*;

    row_t mem [`MVM_ROWS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= din;
        end
    end

    // Old data on a same-address collision
    always_ff @(posedge clk) begin
        dout <= mem[raddr];
    end

endmodule

`default_nettype wire

// ==== design/chunk_if.sv ====
////////////////////////////////////////////////////////////
// Chunk stream from the reorder buffer to the lane array
// Valid/ready handshake, last marks a slice's final column
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

interface chunk_if;
    import mvm_data_pkg::*;

    logic         valid;
    logic         ready;
    logic         last;
    lane_chunks_t chunks;

    // Buffer side
    modport source (
        output valid,
        output chunks,
        output last,
        input  ready
    );

    // Lane array side
    modport sink (
        input  valid,
        input  chunks,
        input  last,
        output ready
    );
endinterface

`default_nettype wire

// ==== design/mvm_ctrl_pkg.sv ====
////////////////////////////////////////////////////////////
// Control types, FSM states and counter widths
////////////////////////////////////////////////////////////
`default_nettype none

`include "mvm_defs.svh"

package mvm_ctrl_pkg;

    localparam int NUM_SLICES  = `MVM_ROWS / (`MVM_BLOCK * `MVM_CORES);
    localparam int NUM_COL_BLK = `MVM_COLS / `MVM_BLOCK;

    typedef enum logic [2:0] {
        ST_IDLE     = 3'd0,
        ST_FILL     = 3'd1,
        ST_SLICE_RD = 3'd2,
        ST_EMIT     = 3'd3,
        ST_DONE     = 3'd4
    } n2r_state_t;

    typedef logic [$clog2(`MVM_ROWS)-1:0]   row_idx_t;
    typedef logic [$clog2(NUM_SLICES)-1:0]  slice_idx_t;
    typedef logic [$clog2(NUM_COL_BLK)-1:0] col_blk_t;

endpackage

`default_nettype wire

// ==== design/mvm_data_pkg.sv ====
////////////////////////////////////////////////////////////
// Datapath types for matrix rows, block chunks and results
// Import inside module bodies, scope in port lists
////////////////////////////////////////////////////////////
`default_nettype none

`include "mvm_defs.svh"

package mvm_data_pkg;

    // Rows held per slice, one block height per core
    localparam int SLICE_ROWS = `MVM_BLOCK * `MVM_CORES;

    typedef logic signed [`MVM_WIDTH-1:0] elem_t;

    // Index 0 is column 0
    typedef elem_t [`MVM_COLS-1:0] row_t;

    // Upper block row first, left column first within a row
    typedef elem_t [`MVM_BLOCK*`MVM_BLOCK-1:0] chunk_t;

    // One chunk per core, core 0 at index 0
    typedef chunk_t [`MVM_CORES-1:0] lane_chunks_t;

    typedef elem_t [`MVM_COLS-1:0] weight_vec_t;

    typedef logic signed [`MVM_ACC_WIDTH-1:0] acc_t;

    // Lowest row of the slice at index 0
    typedef elem_t [SLICE_ROWS-1:0] slice_result_t;

endpackage

`default_nettype wire

// ==== design/mvm_defs.svh ====
////////////////////////////////////////////////////////////
// Build sizes for the matrix-vector multiply front end
// Included by the packages and by modules that size logic
////////////////////////////////////////////////////////////
`ifndef MVM_DEFS_SVH
`define MVM_DEFS_SVH

// Element format, signed Q8.8
`define MVM_WIDTH      16
`define MVM_FRAC       8

// Square block edge, one block per core per beat
`define MVM_BLOCK      2

// Number of multiply-accumulate lanes
`define MVM_CORES      2

// Matrix shape
`define MVM_ROWS       8
`define MVM_COLS       8

// Accumulator width
// 32-bit products summed over COL terms with headroom to spare
`define MVM_ACC_WIDTH  40

`endif
